/* verilog/heap_pkg.sv */
/* operation codes shared by the heap pipeline and its testbench
   any code other than OP_NOP is a one-cycle command */
`default_nettype none

package heap_pkg;

   parameter int OP_WIDTH = 2;

   parameter logic [OP_WIDTH-1:0] OP_NOP     = 2'd0;
   parameter logic [OP_WIDTH-1:0] OP_ENQ     = 2'd1;  // insert a new entry
   parameter logic [OP_WIDTH-1:0] OP_DEQ_MIN = 2'd2;  // drop the head
   parameter logic [OP_WIDTH-1:0] OP_REPLACE = 2'd3;  // overwrite the head, then sift down

endpackage

`default_nettype wire

/* verilog/heap_root.sv */
/* root entry of the heap, empty with full capacity after reset
   the head and stage 0 each get their own registered copy */
`default_nettype none

module heap_root #(
   parameter int N_STAGES       = 4,
   parameter int PRIORITY_WIDTH = 16,
   parameter int DATA_WIDTH     = 8
) (
   input  wire                        clk,
   input  wire                        rstn,
   input  wire                        cur_busy,  // stage 0 owns the root this cycle
   input  wire                        top_we, top_act,
   input  wire  [N_STAGES-1:0]        top_cap,
   input  wire  [PRIORITY_WIDTH-1:0]  top_ts,
   input  wire  [DATA_WIDTH-1:0]      top_data,
   input  wire                        st_we, st_act,
   input  wire  [N_STAGES-1:0]        st_cap,
   input  wire  [PRIORITY_WIDTH-1:0]  st_ts,
   input  wire  [DATA_WIDTH-1:0]      st_data,
   output logic                       head_act, s0_act,
   output logic [N_STAGES-1:0]        head_cap, s0_cap,
   output logic [PRIORITY_WIDTH-1:0]  head_ts, s0_ts,
   output logic [DATA_WIDTH-1:0]      head_data, s0_data
);
   localparam int W = 1 + N_STAGES + PRIORITY_WIDTH + DATA_WIDTH;
   localparam logic [W-1:0] INIT =
      {1'b0, N_STAGES'(2 ** N_STAGES - 1), {(PRIORITY_WIDTH + DATA_WIDTH){1'b0}}};

   logic [W-1:0] root_q, s0_q, wword;
   logic         we;

   // stage 0 and a new command never write in the same cycle
   assign we    = cur_busy ? st_we : top_we;
   assign wword = cur_busy ? {st_act, st_cap, st_ts, st_data}
                           : {top_act, top_cap, top_ts, top_data};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         root_q <= INIT;
         s0_q   <= INIT;
      end else if (we) begin
         root_q <= wword;
         s0_q   <= wword;
      end
   end

   assign {head_act, head_cap, head_ts, head_data} = root_q;
   assign {s0_act, s0_cap, s0_ts, s0_data}         = s0_q;

endmodule

`default_nettype wire

/* verilog/heap_stage.sv */
/* sift logic for one tree level, one cycle per op
   enqueue fills the left subtree before the right one
   relies on the two-cycle issue gap so it never races its neighbours */
`default_nettype none

module heap_stage #(
   parameter int N_STAGES       = 4,
   parameter int PRIORITY_WIDTH = 16,
   parameter int DATA_WIDTH     = 8,
   parameter int LEVEL          = 0
) (
   input  wire                           clk,
   input  wire                           rstn,
   input  wire  [heap_pkg::OP_WIDTH-1:0] in_op,
   input  wire  [N_STAGES-1:0]           in_pos,
   input  wire  [PRIORITY_WIDTH-1:0]     in_ts,
   input  wire  [DATA_WIDTH-1:0]         in_data,
   input  wire                           own_act, left_act, right_act,
   input  wire  [N_STAGES-1:0]           own_cap, left_cap, right_cap,
   input  wire  [PRIORITY_WIDTH-1:0]     own_ts, left_ts, right_ts,
   input  wire  [DATA_WIDTH-1:0]         own_data, left_data, right_data,
   output logic [heap_pkg::OP_WIDTH-1:0] out_op,
   output logic [N_STAGES-1:0]           out_pos,
   output logic [PRIORITY_WIDTH-1:0]     out_ts,
   output logic [DATA_WIDTH-1:0]         out_data,
   output logic                          cur_busy,
   output logic                          own_we, child_we,
   output logic [N_STAGES-1:0]           own_waddr, child_waddr,
   output logic                          own_wact, child_wact,
   output logic [N_STAGES-1:0]           own_wcap, child_wcap,
   output logic [PRIORITY_WIDTH-1:0]     own_wts, child_wts,
   output logic [DATA_WIDTH-1:0]         own_wdata, child_wdata
);
   localparam bit LAST = (LEVEL == N_STAGES - 1);  // no stage below to take an op

   logic [heap_pkg::OP_WIDTH-1:0] cur_op;
   logic [N_STAGES-1:0]           cur_pos;
   logic [PRIORITY_WIDTH-1:0]     cur_ts;
   logic [DATA_WIDTH-1:0]         cur_data;
   logic                          pick_right, own_fits, enq_right;
   logic [N_STAGES-1:0]           c_cap;
   logic [PRIORITY_WIDTH-1:0]     c_ts;
   logic [DATA_WIDTH-1:0]         c_data;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cur_op <= heap_pkg::OP_NOP;
      end else begin
         cur_op <= in_op;
      end
   end

   always_ff @(posedge clk) begin
      cur_pos  <= in_pos;
      cur_ts   <= in_ts;
      cur_data <= in_data;
   end

   assign cur_busy = (cur_op != heap_pkg::OP_NOP);

   // smaller active child, ties go left
   assign pick_right = right_act && (!left_act || right_ts < left_ts);
   assign c_cap      = pick_right ? right_cap : left_cap;
   assign c_ts       = pick_right ? right_ts : left_ts;
   assign c_data     = pick_right ? right_data : left_data;

   // node already in order against every active child
   assign own_fits  = (!left_act || own_ts < left_ts) && (!right_act || own_ts < right_ts);
   assign enq_right = (left_cap == '0);

   assign own_waddr   = cur_pos;
   assign child_waddr = {cur_pos[N_STAGES-2:0], pick_right};

   always_comb begin
      out_op      = heap_pkg::OP_NOP;
      out_pos     = child_waddr;
      out_ts      = cur_ts;
      out_data    = cur_data;
      own_we      = 1'b0;
      own_wact    = own_act;
      own_wcap    = own_cap;
      own_wts     = own_ts;
      own_wdata   = own_data;
      child_we    = 1'b0;
      child_wact  = 1'b0;
      child_wcap  = c_cap;
      child_wts   = own_ts;    // the node pushed down on replace
      child_wdata = own_data;
      case (cur_op)
         heap_pkg::OP_ENQ: begin
            own_we   = 1'b1;
            own_wact = 1'b1;
            own_wcap = own_cap - 1'b1;
            out_pos  = {cur_pos[N_STAGES-2:0], enq_right};
            if (!own_act || cur_ts < own_ts) begin
               own_wts   = cur_ts;
               own_wdata = cur_data;
               out_ts    = own_ts;  // displaced entry carries on
               out_data  = own_data;
            end
            if (own_act) begin
               out_op = heap_pkg::OP_ENQ;
            end
         end
         heap_pkg::OP_DEQ_MIN: begin
            if (left_act || right_act) begin
               out_op     = heap_pkg::OP_DEQ_MIN;
               own_we     = 1'b1;
               own_wact   = 1'b1;
               own_wts    = c_ts;
               own_wdata  = c_data;
               child_we   = 1'b1;
               child_wcap = c_cap + 1'b1;  // child left empty for the next level
            end
         end
         heap_pkg::OP_REPLACE: begin
            if (!own_fits) begin
               out_op     = heap_pkg::OP_REPLACE;
               own_we     = 1'b1;
               own_wts    = c_ts;
               own_wdata  = c_data;
               child_we   = 1'b1;
               child_wact = 1'b1;
            end
         end
         default: ;
      endcase
      if (LAST) begin
         out_op = heap_pkg::OP_NOP;
      end
   end

endmodule

`default_nettype wire

/* verilog/level_mem.sv */
/* storage for one tree level, left children in bank 0 and right children in bank 1
   read data follows the address by one cycle, a write in that cycle is forwarded
   contents start empty with full subtree capacity, there is no reset */
`default_nettype none

module level_mem #(
   parameter int N_STAGES       = 4,
   parameter int PRIORITY_WIDTH = 16,
   parameter int DATA_WIDTH     = 8,
   parameter int LEVEL          = 1
) (
   input  wire                           clk,
   input  wire  [heap_pkg::OP_WIDTH-1:0] op_prev_next,  // op entering the parent stage
   input  wire  [heap_pkg::OP_WIDTH-1:0] op_cur_next,   // op entering this level's stage
   input  wire                           cur_busy,
   input  wire  [N_STAGES-1:0]           raddr_prev,    // left child of the parent
   input  wire  [N_STAGES-1:0]           raddr_cur,
   output logic                          left_act, right_act, own_act,
   output logic [N_STAGES-1:0]           left_cap, right_cap, own_cap,
   output logic [PRIORITY_WIDTH-1:0]     left_ts, right_ts, own_ts,
   output logic [DATA_WIDTH-1:0]         left_data, right_data, own_data,
   input  wire                           prev_we, cur_we,
   input  wire  [N_STAGES-1:0]           prev_waddr, cur_waddr,
   input  wire                           prev_wact, cur_wact,
   input  wire  [N_STAGES-1:0]           prev_wcap, cur_wcap,
   input  wire  [PRIORITY_WIDTH-1:0]     prev_wts, cur_wts,
   input  wire  [DATA_WIDTH-1:0]         prev_wdata, cur_wdata
);
   localparam int W     = 1 + N_STAGES + PRIORITY_WIDTH + DATA_WIDTH;
   localparam int DEPTH = 2 ** (LEVEL - 1);
   localparam int IW    = (LEVEL > 1) ? LEVEL - 1 : 1;
   localparam logic [W-1:0] INIT =
      {1'b0, N_STAGES'(2 ** (N_STAGES - LEVEL) - 1), {(PRIORITY_WIDTH + DATA_WIDTH){1'b0}}};

   logic [W-1:0]          bank_0 [DEPTH];
   logic [W-1:0]          bank_1 [DEPTH];
   logic [N_STAGES-1:0]   raddr, waddr;
   logic [IW-1:0]         ridx, widx;
   logic [W-1:0]          wword, wword_q, rd0_q, rd1_q, word_0, word_1;
   logic                  ren, we, we_0, we_1, hit0_q, hit1_q, rsel_q;

   // the two-cycle issue gap keeps both readers and both writers apart
   assign ren   = (op_prev_next != heap_pkg::OP_NOP) || (op_cur_next != heap_pkg::OP_NOP);
   assign raddr = (op_cur_next != heap_pkg::OP_NOP) ? raddr_cur : raddr_prev;
   assign waddr = cur_busy ? cur_waddr : prev_waddr;
   assign we    = cur_busy ? cur_we : prev_we;
   assign wword = cur_busy ? {cur_wact, cur_wcap, cur_wts, cur_wdata}
                           : {prev_wact, prev_wcap, prev_wts, prev_wdata};
   assign we_0  = we & ~waddr[0];
   assign we_1  = we & waddr[0];

   if (LEVEL == 1) begin : g_single
      // one word per bank
      assign ridx = '0;
      assign widx = '0;
   end else begin : g_banked
      assign ridx = raddr[LEVEL-1:1];
      assign widx = waddr[LEVEL-1:1];
   end

   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         bank_0[i] = INIT;
         bank_1[i] = INIT;
      end
   end

   always @(posedge clk) begin
      if (we_0) begin
         bank_0[widx] <= wword;
      end
      if (we_1) begin
         bank_1[widx] <= wword;
      end
   end

   // read port holds its result until the next request
   always_ff @(posedge clk) begin
      if (ren) begin
         rd0_q   <= bank_0[ridx];
         rd1_q   <= bank_1[ridx];
         hit0_q  <= we_0 && (widx == ridx);
         hit1_q  <= we_1 && (widx == ridx);
         wword_q <= wword;
         rsel_q  <= raddr[0];
      end
   end

   assign word_0 = hit0_q ? wword_q : rd0_q;
   assign word_1 = hit1_q ? wword_q : rd1_q;

   assign {left_act, left_cap, left_ts, left_data}     = word_0;
   assign {right_act, right_cap, right_ts, right_data} = word_1;
   assign {own_act, own_cap, own_ts, own_data}         = rsel_q ? word_1 : word_0;

endmodule

`default_nettype wire

/* verilog/min_heap.sv */
/* pipelined min-heap priority queue, one stage and one memory per tree level
   a command is taken only while ready is high, so at most one every other cycle
   enqueue needs capacity != 0, dequeue and replace need out_valid */
`default_nettype none

module min_heap #(
   parameter int N_STAGES       = 4,   // tree levels, 2**N_STAGES-1 entries
   parameter int PRIORITY_WIDTH = 16,
   parameter int DATA_WIDTH     = 8
) (
   input  wire                           clk,
   input  wire                           rstn,
   input  wire  [heap_pkg::OP_WIDTH-1:0] in_op,
   input  wire  [PRIORITY_WIDTH-1:0]     in_ts,
   input  wire  [DATA_WIDTH-1:0]         in_data,
   output logic                          ready,
   output logic                          out_valid,
   output logic [PRIORITY_WIDTH-1:0]     out_ts,
   output logic [DATA_WIDTH-1:0]         out_data,
   output logic [N_STAGES-1:0]           capacity
);
   // op pipeline, element k feeds stage k
   logic [heap_pkg::OP_WIDTH-1:0] pipe_op [N_STAGES+1];
   logic [N_STAGES-1:0]           pipe_pos [N_STAGES+1];
   logic [PRIORITY_WIDTH-1:0]     pipe_ts [N_STAGES+1];
   logic [DATA_WIDTH-1:0]         pipe_data [N_STAGES+1];
   logic                          busy [N_STAGES];

   // entries seen by each stage
   logic                      own_act [N_STAGES], left_act [N_STAGES], right_act [N_STAGES];
   logic [N_STAGES-1:0]       own_cap [N_STAGES], left_cap [N_STAGES], right_cap [N_STAGES];
   logic [PRIORITY_WIDTH-1:0] own_ts [N_STAGES], left_ts [N_STAGES], right_ts [N_STAGES];
   logic [DATA_WIDTH-1:0]     own_data [N_STAGES], left_data [N_STAGES], right_data [N_STAGES];

   // writes issued by each stage
   logic                      own_we [N_STAGES], child_we [N_STAGES];
   logic [N_STAGES-1:0]       own_waddr [N_STAGES], child_waddr [N_STAGES];
   logic                      own_wact [N_STAGES], child_wact [N_STAGES];
   logic [N_STAGES-1:0]       own_wcap [N_STAGES], child_wcap [N_STAGES];
   logic [PRIORITY_WIDTH-1:0] own_wts [N_STAGES], child_wts [N_STAGES];
   logic [DATA_WIDTH-1:0]     own_wdata [N_STAGES], child_wdata [N_STAGES];

   logic                      top_we, top_act;
   logic [N_STAGES-1:0]       top_cap;
   logic [PRIORITY_WIDTH-1:0] top_ts;
   logic [DATA_WIDTH-1:0]     top_data;

   assign pipe_op[0]   = in_op;
   assign pipe_pos[0]  = N_STAGES'(1);  // root index
   assign pipe_ts[0]   = in_ts;
   assign pipe_data[0] = in_data;

   assign ready = !busy[0];

   // root is touched in the accept cycle only by replace and dequeue
   always_comb begin
      top_we   = 1'b0;
      top_act  = 1'b0;
      top_cap  = capacity;
      top_ts   = in_ts;
      top_data = in_data;
      case (in_op)
         heap_pkg::OP_REPLACE: begin
            top_we  = 1'b1;
            top_act = 1'b1;
         end
         heap_pkg::OP_DEQ_MIN: begin
            top_we  = 1'b1;
            top_cap = capacity + 1'b1;  // stage 0 refills the emptied root
         end
         default: ;
      endcase
   end

   heap_root #(
      .N_STAGES(N_STAGES),
      .PRIORITY_WIDTH(PRIORITY_WIDTH),
      .DATA_WIDTH(DATA_WIDTH)
   ) root_i (
      .clk(clk),
      .rstn(rstn),
      .cur_busy(busy[0]),
      .top_we(top_we), .top_act(top_act), .top_cap(top_cap),
      .top_ts(top_ts), .top_data(top_data),
      .st_we(own_we[0]), .st_act(own_wact[0]), .st_cap(own_wcap[0]),
      .st_ts(own_wts[0]), .st_data(own_wdata[0]),
      .head_act(out_valid), .head_cap(capacity), .head_ts(out_ts), .head_data(out_data),
      .s0_act(own_act[0]), .s0_cap(own_cap[0]), .s0_ts(own_ts[0]), .s0_data(own_data[0])
   );

   for (genvar k = 0; k < N_STAGES; k++) begin : g_level
      heap_stage #(
         .N_STAGES(N_STAGES),
         .PRIORITY_WIDTH(PRIORITY_WIDTH),
         .DATA_WIDTH(DATA_WIDTH),
         .LEVEL(k)
      ) stage_i (
         .clk(clk),
         .rstn(rstn),
         .in_op(pipe_op[k]), .in_pos(pipe_pos[k]), .in_ts(pipe_ts[k]), .in_data(pipe_data[k]),
         .own_act(own_act[k]), .left_act(left_act[k]), .right_act(right_act[k]),
         .own_cap(own_cap[k]), .left_cap(left_cap[k]), .right_cap(right_cap[k]),
         .own_ts(own_ts[k]), .left_ts(left_ts[k]), .right_ts(right_ts[k]),
         .own_data(own_data[k]), .left_data(left_data[k]), .right_data(right_data[k]),
         .out_op(pipe_op[k+1]), .out_pos(pipe_pos[k+1]),
         .out_ts(pipe_ts[k+1]), .out_data(pipe_data[k+1]),
         .cur_busy(busy[k]),
         .own_we(own_we[k]), .child_we(child_we[k]),
         .own_waddr(own_waddr[k]), .child_waddr(child_waddr[k]),
         .own_wact(own_wact[k]), .child_wact(child_wact[k]),
         .own_wcap(own_wcap[k]), .child_wcap(child_wcap[k]),
         .own_wts(own_wts[k]), .child_wts(child_wts[k]),
         .own_wdata(own_wdata[k]), .child_wdata(child_wdata[k])
      );

      if (k < N_STAGES - 1) begin : g_mem
         level_mem #(
            .N_STAGES(N_STAGES),
            .PRIORITY_WIDTH(PRIORITY_WIDTH),
            .DATA_WIDTH(DATA_WIDTH),
            .LEVEL(k + 1)
         ) mem_i (
            .clk(clk),
            .op_prev_next(pipe_op[k]),
            .op_cur_next(pipe_op[k+1]),
            .cur_busy(busy[k+1]),
            .raddr_prev({pipe_pos[k][N_STAGES-2:0], 1'b0}),  // left child of the parent
            .raddr_cur(pipe_pos[k+1]),
            .left_act(left_act[k]), .right_act(right_act[k]), .own_act(own_act[k+1]),
            .left_cap(left_cap[k]), .right_cap(right_cap[k]), .own_cap(own_cap[k+1]),
            .left_ts(left_ts[k]), .right_ts(right_ts[k]), .own_ts(own_ts[k+1]),
            .left_data(left_data[k]), .right_data(right_data[k]), .own_data(own_data[k+1]),
            .prev_we(child_we[k]), .cur_we(own_we[k+1]),
            .prev_waddr(child_waddr[k]), .cur_waddr(own_waddr[k+1]),
            .prev_wact(child_wact[k]), .cur_wact(own_wact[k+1]),
            .prev_wcap(child_wcap[k]), .cur_wcap(own_wcap[k+1]),
            .prev_wts(child_wts[k]), .cur_wts(own_wts[k+1]),
            .prev_wdata(child_wdata[k]), .cur_wdata(own_wdata[k+1])
         );
      end else begin : g_leaf
         // nothing below the last level, children read as empty with no room
         assign left_act[k]   = 1'b0;
         assign right_act[k]  = 1'b0;
         assign left_cap[k]   = '0;
         assign right_cap[k]  = '0;
         assign left_ts[k]    = '0;
         assign right_ts[k]   = '0;
         assign left_data[k]  = '0;
         assign right_data[k] = '0;
      end
   end

endmodule

`default_nettype wire

/* include/heap_ref.svh */
/* reference model of the queue contents, a flat unsorted array of 15 entries
   assumes unique priorities, so the minimum is never ambiguous */
`ifndef HEAP_REF_SVH
`define HEAP_REF_SVH

localparam int REF_SIZE = 15;  // 2**4-1 for the default tree depth

logic [15:0] ref_ts [REF_SIZE];
logic [7:0]  ref_data [REF_SIZE];
int          ref_count = 0;

// position of the smallest priority, only valid while ref_count != 0
function automatic int ref_min_index();
   int best;
   best = 0;
   for (int i = 1; i < ref_count; i++) begin
      if (ref_ts[i] < ref_ts[best]) begin
         best = i;
      end
   end
   return best;
endfunction

function automatic logic [15:0] ref_min_ts();
   return ref_ts[ref_min_index()];
endfunction

function automatic logic [7:0] ref_min_data();
   return ref_data[ref_min_index()];
endfunction

function automatic void ref_insert(input logic [15:0] ts, input logic [7:0] data);
   ref_ts[ref_count]   = ts;
   ref_data[ref_count] = data;
   ref_count           = ref_count + 1;
endfunction

function automatic void ref_remove_min();
   int idx;
   idx           = ref_min_index();
   ref_ts[idx]   = ref_ts[ref_count-1];  // last entry fills the hole
   ref_data[idx] = ref_data[ref_count-1];
   ref_count     = ref_count - 1;
endfunction

`endif

/* tb/tb_min_heap.sv */
/* testbench for min_heap with default parameters and a 15-entry tree
   priorities carry a running counter in their low 10 bits to stay unique */
`default_nettype none

module tb_min_heap;

   localparam int N_OPS       = 15 + 15 + 6 + 10 + 500;  // fill, drain, setup, replace, mix
   localparam int CYCLE_LIMIT = 3 * N_OPS + 300;          // 3 cycles per op plus reset slack

   logic                          clk;
   logic                          rstn;
   logic [heap_pkg::OP_WIDTH-1:0] in_op;
   logic [15:0]                   in_ts;
   logic [7:0]                    in_data;
   logic                          ready;
   logic                          out_valid;
   logic [15:0]                   out_ts;
   logic [7:0]                    out_data;
   logic [3:0]                    capacity;

   logic [heap_pkg::OP_WIDTH-1:0] last_op_q;  // op the DUT sampled on the last edge
   logic [31:0]                   rng_state = 32'h399d45c9;
   logic [9:0]                    uniq_cnt = '0;
   logic [15:0]                   last_head;
   int                            cycles = 0;
   int                            checks = 0;
   int                            errors = 0;

   `include "heap_ref.svh"

   min_heap min_heap_i (
      .clk(clk),
      .rstn(rstn),
      .in_op(in_op),
      .in_ts(in_ts),
      .in_data(in_data),
      .ready(ready),
      .out_valid(out_valid),
      .out_ts(out_ts),
      .out_data(out_data),
      .capacity(capacity)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      last_op_q <= in_op;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_entry(output logic [15:0] ts, output logic [7:0] data);
      rng_state = xorshift32(rng_state);
      ts        = {rng_state[21:16], uniq_cnt};
      data      = rng_state[31:24];
      uniq_cnt  = uniq_cnt + 1'b1;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_counts();
      $display("checks: %0d, errors: %0d", checks, errors);
   endtask

   task automatic wait_ready();
      @(negedge clk);
      while (!ready) begin
         @(negedge clk);
      end
   endtask

   // drive one command, update the model on the accepting edge, wait till settled
   task automatic issue_op(input logic [heap_pkg::OP_WIDTH-1:0] op, input logic [15:0] ts,
                           input logic [7:0] data);
      @(posedge clk);
      in_op   <= op;
      in_ts   <= ts;
      in_data <= data;
      @(posedge clk);
      in_op <= heap_pkg::OP_NOP;
      if (op == heap_pkg::OP_DEQ_MIN || op == heap_pkg::OP_REPLACE) begin
         ref_remove_min();
      end
      if (op == heap_pkg::OP_ENQ || op == heap_pkg::OP_REPLACE) begin
         ref_insert(ts, data);
      end
      wait_ready();
   endtask

   task automatic enqueue_new();
      logic [15:0] ts;
      logic [7:0]  data;
      next_entry(ts, data);
      issue_op(heap_pkg::OP_ENQ, ts, data);
   endtask

   task automatic replace_new();
      logic [15:0] ts;
      logic [7:0]  data;
      next_entry(ts, data);
      issue_op(heap_pkg::OP_REPLACE, ts, data);
   endtask

   task automatic dequeue_min();
      issue_op(heap_pkg::OP_DEQ_MIN, '0, '0);
   endtask

   // only ops that the current fill level allows
   task automatic random_op();
      logic [31:0] pick;
      rng_state = xorshift32(rng_state);
      pick      = rng_state % 32'd3;
      if (ref_count == 0) begin
         enqueue_new();
      end else if (pick == 32'd0 && ref_count < REF_SIZE) begin
         enqueue_new();
      end else if (pick == 32'd2) begin
         replace_new();
      end else begin
         dequeue_min();
      end
   endtask

   // head and capacity are final whenever ready is high after an idle edge
   always @(negedge clk) begin
      if (rstn) begin
         // ready drops for exactly the one cycle after a command is taken
         check_value("ready", 32'(ready), 32'(last_op_q == heap_pkg::OP_NOP));
         if (ready && last_op_q == heap_pkg::OP_NOP) begin
            check_value("out_valid", 32'(out_valid), 32'(ref_count != 0));
            check_value("capacity", 32'(capacity), 32'(REF_SIZE - ref_count));
            if (ref_count != 0) begin
               check_value("out_ts", 32'(out_ts), 32'(ref_min_ts()));
               check_value("out_data", 32'(out_data), 32'(ref_min_data()));
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         report_counts();
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      clk     = 1'b0;
      rstn    = 1'b0;
      in_op   = heap_pkg::OP_NOP;
      in_ts   = '0;
      in_data = '0;
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      assert (ready) else begin
         errors++;
         $display("ready is not high after reset");
      end
      check_value("out_valid", 32'(out_valid), 32'd0);
      check_value("capacity", 32'(capacity), 32'd15);

      repeat (15) enqueue_new();  // up to full
      check_value("capacity", 32'(capacity), 32'd0);
      check_value("out_valid", 32'(out_valid), 32'd1);

      last_head = out_ts;
      repeat (15) begin
         dequeue_min();
         if (ref_count != 0) begin
            checks++;
            assert (out_ts > last_head) else begin
               errors++;
               $display("mismatch at %0t: out_ts %h not above previous head %h",
                        $time, out_ts, last_head);
            end
            last_head = out_ts;
         end
      end
      check_value("out_valid", 32'(out_valid), 32'd0);

      repeat (6) enqueue_new();
      repeat (10) replace_new();  // capacity must not move

      repeat (500) random_op();

      @(negedge clk);
      report_counts();
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
verilog/heap_pkg.sv
verilog/heap_root.sv
verilog/heap_stage.sv
verilog/level_mem.sv
verilog/min_heap.sv
tb/tb_min_heap.sv

/* run.sh */
#!/bin/sh
# build and run the min_heap testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module tb_min_heap -o tb_min_heap
./obj_dir/tb_min_heap > sim.log 2>&1
cat sim.log

if grep -q 'All tests passed!' sim.log; then
   exit 0
fi
exit 1
